// File: hdl/audio_config.svh
/* build-time constants for the audio command path
   uart timing assumes clk_12M at 12.288 MHz */
`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

// sample width on both i2s streams
`define AUDIO_W 16

// 12.288 MHz / 9600 baud
`define UART_CLKS_PER_BIT 1280

// echo delay in frames, ECHO_AW must be its log2
`define ECHO_DEPTH 32
`define ECHO_AW 5

// magnitude above which the voice flag rises
`define VOICE_THRESHOLD 16'h1000

`endif

// File: hdl/audio_pkg.sv
/* types passed between the capture, decode, execute and result blocks
   sample valid is a one-cycle strobe, data is good only in that cycle */
`default_nettype none

`include "audio_config.svh"

package audio_pkg;

  // effect picked by the high nibble of a command byte
  typedef enum logic [1:0] {
    EFFECT_BYPASS = 2'd0,
    EFFECT_ECHO   = 2'd1,
    EFFECT_GAIN   = 2'd2
  } effect_e;

  // current setting, held until the next good command
  typedef struct packed {
    effect_e effect;
    logic    gain_up;  // 1 doubles, 0 halves
  } effect_cfg_t;

  typedef struct packed {
    logic                       valid;  // single-cycle strobe
    logic signed [`AUDIO_W-1:0] data;
  } sample_t;

  // uart receiver states, only cmd_decode uses these
  typedef enum logic [1:0] {
    UART_IDLE  = 2'd0,
    UART_START = 2'd1,
    UART_DATA  = 2'd2,
    UART_STOP  = 2'd3
  } uart_state_e;

endpackage

`default_nettype wire

// File: hdl/i2s_capture.sv
/* left channel only, the right word is dropped
   sck must stay well below clk_12M/4 so every edge is seen after sync */
`timescale 1ns/1ps
`default_nettype none

`include "audio_config.svh"

module i2s_capture (
  input  logic               clk_12M,
  input  logic               sys_rst,
  input  logic               i_i2s_sck,
  input  logic               i_i2s_ws,
  input  logic               i_i2s_sd,
  output audio_pkg::sample_t o_sample
);
  import audio_pkg::*;

  localparam int CNT_W = $clog2(`AUDIO_W + 1);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`AUDIO_W - 1);
  localparam logic [CNT_W-1:0] WORD_END = CNT_W'(`AUDIO_W);

  logic [1:0]          sck_sync;
  logic [1:0]          ws_sync;
  logic [1:0]          sd_sync;
  logic                sck_d;
  logic                sck_rise;
  logic                slot_ws;  // channel of the slot now on sd
  logic                capture;
  logic [CNT_W-1:0]    bit_cnt;
  logic [`AUDIO_W-1:0] shift_reg;
  logic                word_done;

  assign sck_rise = sck_sync[1] & ~sck_d;
  assign capture  = sck_rise & ~slot_ws & (bit_cnt != WORD_END);  // left slots, first 16 bits

  always_ff @(posedge clk_12M or negedge sys_rst) begin
    if (!sys_rst) begin
      sck_sync  <= '0;
      ws_sync   <= '0;
      sd_sync   <= '0;
      sck_d     <= 1'b0;
      slot_ws   <= 1'b1;
      bit_cnt   <= WORD_END;  // idle until a real left edge
      word_done <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[0], i_i2s_sck};
      ws_sync   <= {ws_sync[0], i_i2s_ws};
      sd_sync   <= {sd_sync[0], i_i2s_sd};
      sck_d     <= sck_sync[1];
      word_done <= capture && (bit_cnt == LAST_BIT);
      if (sck_rise) begin
        slot_ws <= ws_sync[1];
        if (ws_sync[1] != slot_ws) begin
          bit_cnt <= '0;  // ws moved, msb comes one bit later
        end else if (bit_cnt != WORD_END) begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_12M) begin
    if (capture) begin
      shift_reg <= {shift_reg[`AUDIO_W-2:0], sd_sync[1]};  // msb first
    end
  end

  assign o_sample.valid = word_done;
  assign o_sample.data  = shift_reg;

endmodule

`default_nettype wire

// File: hdl/cmd_decode.sv
/* 8N1 receiver, one command byte sets the effect until the next one
   a frame with a low stop bit is thrown away */
`timescale 1ns/1ps
`default_nettype none

`include "audio_config.svh"

module cmd_decode (
  input  logic                   clk_12M,
  input  logic                   sys_rst,
  input  logic                   i_uart_rx,
  output audio_pkg::effect_cfg_t o_cfg
);
  import audio_pkg::*;

  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);

  uart_state_e      state;
  logic [1:0]       rx_sync;
  logic             rx_s;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       rx_byte;
  logic             bit_end;
  logic             stop_sample;  // mid-point of the stop bit
  effect_cfg_t      cfg_q;

  function automatic effect_cfg_t decode_cmd(input logic [7:0] cmd);
    effect_cfg_t cfg;
    case (cmd[7:4])
      4'h1:    cfg.effect = EFFECT_ECHO;
      4'h2:    cfg.effect = EFFECT_GAIN;
      default: cfg.effect = EFFECT_BYPASS;  // unknown falls back to dry signal
    endcase
    cfg.gain_up = cmd[0];
    return cfg;
  endfunction

  assign rx_s        = rx_sync[1];
  assign bit_end     = (clk_cnt == BIT_LAST);
  assign stop_sample = (state == UART_STOP) && bit_end;

  always_ff @(posedge clk_12M or negedge sys_rst) begin
    if (!sys_rst) begin
      rx_sync <= 2'b11;  // line idles high
      state   <= UART_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      cfg_q   <= '{effect: EFFECT_BYPASS, gain_up: 1'b0};
    end else begin
      rx_sync <= {rx_sync[0], i_uart_rx};
      case (state)
        UART_IDLE: begin
          clk_cnt <= '0;
          if (!rx_s) state <= UART_START;
        end
        UART_START: begin
          if (clk_cnt == HALF_LAST) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_s ? UART_IDLE : UART_DATA;  // glitch on the line
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= UART_STOP;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          if (bit_end) begin
            clk_cnt <= '0;
            state   <= UART_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
      if (stop_sample && rx_s) cfg_q <= decode_cmd(rx_byte);
    end
  end

  always_ff @(posedge clk_12M) begin
    if (state == UART_DATA && bit_end) begin
      rx_byte <= {rx_s, rx_byte[7:1]};  // lsb first
    end
  end

  assign o_cfg = cfg_q;

endmodule

`default_nettype wire

// File: hdl/effect_execute.sv
/* one sample in flight, result registered one cycle after the input strobe
   echo reads zero until ECHO_DEPTH samples have been written */
`timescale 1ns/1ps
`default_nettype none

`include "audio_config.svh"

module effect_execute (
  input  logic                   clk_12M,
  input  logic                   sys_rst,
  input  audio_pkg::effect_cfg_t i_cfg,
  input  audio_pkg::sample_t     i_sample,
  output audio_pkg::sample_t     o_sample
);
  import audio_pkg::*;

  localparam logic [`ECHO_AW:0] FILL_FULL = (`ECHO_AW + 1)'(`ECHO_DEPTH);
  localparam logic signed [`AUDIO_W-1:0] SAT_MAX = {1'b0, {(`AUDIO_W - 1){1'b1}}};
  localparam logic signed [`AUDIO_W-1:0] SAT_MIN = {1'b1, {(`AUDIO_W - 1){1'b0}}};

  logic signed [`AUDIO_W-1:0] delay_mem [`ECHO_DEPTH];
  logic [`ECHO_AW-1:0]        wr_ptr;  // also points at the oldest entry
  logic [`ECHO_AW:0]          fill_cnt;
  logic signed [`AUDIO_W-1:0] in_data;
  logic signed [`AUDIO_W-1:0] delayed;
  logic signed [`AUDIO_W:0]   echo_sum;
  logic signed [`AUDIO_W-1:0] result;
  logic                       out_valid;
  logic signed [`AUDIO_W-1:0] out_data;

  always_comb begin
    in_data  = i_sample.data;
    delayed  = (fill_cnt == FILL_FULL) ? delay_mem[wr_ptr] : '0;
    echo_sum = {in_data[`AUDIO_W-1], in_data} + {delayed[`AUDIO_W-1], delayed};
    case (i_cfg.effect)
      EFFECT_ECHO: begin
        result = echo_sum[`AUDIO_W:1];  // sum >>> 1, no overflow at 17 bits
      end
      EFFECT_GAIN: begin
        if (!i_cfg.gain_up) begin
          result = in_data >>> 1;
        end else if (in_data[`AUDIO_W-1] != in_data[`AUDIO_W-2]) begin
          result = in_data[`AUDIO_W-1] ? SAT_MIN : SAT_MAX;  // doubling would wrap
        end else begin
          result = in_data <<< 1;
        end
      end
      default: begin
        result = in_data;
      end
    endcase
  end

  always_ff @(posedge clk_12M or negedge sys_rst) begin
    if (!sys_rst) begin
      wr_ptr    <= '0;
      fill_cnt  <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= i_sample.valid;
      if (i_sample.valid) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at ECHO_DEPTH
        if (fill_cnt != FILL_FULL) fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_12M) begin
    if (i_sample.valid) begin
      delay_mem[wr_ptr] <= in_data;  // old entry already read above
      out_data          <= result;
    end
  end

  assign o_sample.valid = out_valid;
  assign o_sample.data  = out_data;

endmodule

`default_nettype wire

// File: hdl/audio_result.sv
/* same word on left and right, word taken at the start of each left slot
   a newer sample overwrites the held one, there is no back-pressure */
`timescale 1ns/1ps
`default_nettype none

`include "audio_config.svh"

module audio_result (
  input  logic               clk_12M,
  input  logic               sys_rst,
  input  logic               i_i2s_sck,
  input  logic               i_i2s_ws,
  input  audio_pkg::sample_t i_sample,
  output logic               o_i2s_sd,
  output logic               o_voice_flag
);
  import audio_pkg::*;

  localparam logic [`AUDIO_W:0] THRESH = (`AUDIO_W + 1)'(`VOICE_THRESHOLD);

  logic [1:0]          sck_sync;
  logic [1:0]          ws_sync;
  logic                sck_d;
  logic                ws_d;
  logic                sck_fall;
  logic                ws_fall;
  logic                ws_edge;
  logic                load_pend;   // ws moved, load on next sck fall
  logic [`AUDIO_W-1:0] hold_word;   // latest processed sample
  logic [`AUDIO_W-1:0] frame_word;  // word for both slots of this frame
  logic [`AUDIO_W-1:0] shift_reg;
  logic [`AUDIO_W:0]   sample_ext;
  logic [`AUDIO_W:0]   magnitude;

  assign sck_fall   = ~sck_sync[1] & sck_d;
  assign ws_fall    = ~ws_sync[1] & ws_d;
  assign ws_edge    = ws_sync[1] ^ ws_d;
  assign sample_ext = {i_sample.data[`AUDIO_W-1], i_sample.data};
  assign magnitude  = sample_ext[`AUDIO_W] ? -sample_ext : sample_ext;  // 0x8000 fits

  always_ff @(posedge clk_12M or negedge sys_rst) begin
    if (!sys_rst) begin
      sck_sync     <= '0;
      ws_sync      <= '0;
      sck_d        <= 1'b0;
      ws_d         <= 1'b0;
      load_pend    <= 1'b0;
      hold_word    <= '0;
      frame_word   <= '0;
      shift_reg    <= '0;
      o_i2s_sd     <= 1'b0;
      o_voice_flag <= 1'b0;
    end else begin
      sck_sync <= {sck_sync[0], i_i2s_sck};
      ws_sync  <= {ws_sync[0], i_i2s_ws};
      sck_d    <= sck_sync[1];
      ws_d     <= ws_sync[1];
      if (i_sample.valid) begin
        hold_word    <= i_sample.data;
        o_voice_flag <= (magnitude > THRESH);
      end
      if (ws_fall) frame_word <= hold_word;
      if (sck_fall) begin
        o_i2s_sd <= shift_reg[`AUDIO_W-1];  // old lsb goes out in the slot after ws
        if (load_pend || ws_edge) begin
          shift_reg <= ws_fall ? hold_word : frame_word;
        end else begin
          shift_reg <= shift_reg << 1;
        end
        load_pend <= 1'b0;
      end else if (ws_edge) begin
        load_pend <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/audio_top.sv
/* single clock domain, ADC and DAC share the i2s bit clock and word select
   DAC left word of frame k carries the result for ADC left word of frame k-1 */
`timescale 1ns/1ps
`default_nettype none

module audio_top (
  input  logic clk_12M,
  input  logic sys_rst,
  input  logic i_uart_rx,
  input  logic i_i2s_sck,
  input  logic i_i2s_ws,
  input  logic i_i2s_sd,
  output logic o_i2s_sd,
  output logic o_voice_flag
);
  import audio_pkg::*;

  sample_t     in_sample;   // captured left word
  effect_cfg_t cfg;         // current effect
  sample_t     out_sample;  // processed word

  i2s_capture u_capture (
    .clk_12M   (clk_12M),
    .sys_rst   (sys_rst),
    .i_i2s_sck (i_i2s_sck),
    .i_i2s_ws  (i_i2s_ws),
    .i_i2s_sd  (i_i2s_sd),
    .o_sample  (in_sample)
  );

  cmd_decode u_cmd_decode (
    .clk_12M   (clk_12M),
    .sys_rst   (sys_rst),
    .i_uart_rx (i_uart_rx),
    .o_cfg     (cfg)
  );

  effect_execute u_execute (
    .clk_12M  (clk_12M),
    .sys_rst  (sys_rst),
    .i_cfg    (cfg),
    .i_sample (in_sample),
    .o_sample (out_sample)
  );

  audio_result u_result (
    .clk_12M      (clk_12M),
    .sys_rst      (sys_rst),
    .i_i2s_sck    (i_i2s_sck),
    .i_i2s_ws     (i_i2s_ws),
    .i_sample     (out_sample),
    .o_i2s_sd     (o_i2s_sd),
    .o_voice_flag (o_voice_flag)
  );

endmodule

`default_nettype wire

// File: tb/audio_assert.sv
/* bound into audio_top, watches strobes, config updates and reset levels
   stop_sample is taken from the uart receiver inside cmd_decode */
`timescale 1ns/1ps
`default_nettype none

module audio_assert (
  input logic               clk_12M,
  input logic               sys_rst,
  input audio_pkg::sample_t in_sample,
  input audio_pkg::effect_cfg_t cfg,
  input logic               stop_sample,
  input logic               o_i2s_sd,
  input logic               o_voice_flag
);
  import audio_pkg::*;

  int fail_cnt = 0;  // read by the testbench at the end

  a_valid_strobe: assert property (@(posedge clk_12M) disable iff (!sys_rst)
    in_sample.valid |=> !in_sample.valid)
    else begin
      $error("in_sample.valid high for two cycles");
      fail_cnt++;
    end

  a_cfg_update: assert property (@(posedge clk_12M) disable iff (!sys_rst)
    (cfg != $past(cfg)) |-> $past(stop_sample))
    else begin
      $error("cfg changed outside a uart stop sample");
      fail_cnt++;
    end

  a_reset_low: assert property (@(posedge clk_12M)
    !sys_rst |-> (!o_voice_flag && !o_i2s_sd))
    else begin
      $error("outputs not low during reset");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// File: tb/audio_tb.sv
/* i2s frame of 32 sck periods, each 16 clk_12M cycles long
   uart bytes go out while the i2s bus is paused
   checks left and right dac words and the voice flag every frame */
`timescale 1ns/1ps
`default_nettype none

`include "audio_config.svh"

module audio_tb;

  typedef struct packed {
    logic        has_cmd;
    logic        bad_stop;  // send the byte with a low stop bit
    logic [7:0]  cmd;
    logic [7:0]  frames;
    logic        rnd;
    logic [15:0] pattern;
  } row_t;

  localparam int NROWS = 12;
  localparam int BIT_CLKS = `UART_CLKS_PER_BIT;

  logic clk_12M;
  logic sys_rst;
  logic i_uart_rx;
  logic i_i2s_sck;
  logic i_i2s_ws;
  logic i_i2s_sd;
  logic o_i2s_sd;
  logic o_voice_flag;

  row_t        rows [NROWS];
  logic [15:0] hist [$];  // every left word sent since reset
  logic [7:0]  model_cmd;
  logic [15:0] y_prev;
  logic [15:0] y_prev2;
  logic [31:0] prev_bits;
  int          frame_cnt;
  int          errors;
  longint      limit_cycles;

  audio_top i_audio_top (
    .clk_12M      (clk_12M),
    .sys_rst      (sys_rst),
    .i_uart_rx    (i_uart_rx),
    .i_i2s_sck    (i_i2s_sck),
    .i_i2s_ws     (i_i2s_ws),
    .i_i2s_sd     (i_i2s_sd),
    .o_i2s_sd     (o_i2s_sd),
    .o_voice_flag (o_voice_flag)
  );

  bind audio_top audio_assert u_assert (
    .clk_12M      (clk_12M),
    .sys_rst      (sys_rst),
    .in_sample    (in_sample),
    .cfg          (cfg),
    .stop_sample  (u_cmd_decode.stop_sample),
    .o_i2s_sd     (o_i2s_sd),
    .o_voice_flag (o_voice_flag)
  );

  initial begin
    clk_12M = 1'b0;
    forever #2 clk_12M = ~clk_12M;
  end

  // expected output word from the command byte, input and echo tap
  function automatic logic [15:0] effect_ref(input logic [7:0] cmd, input logic [15:0] x,
                                             input logic [15:0] d);
    int xi;
    int di;
    int r;
    xi = $signed(x);
    di = $signed(d);
    case (cmd[7:4])
      4'h1: r = (xi + di) >>> 1;
      4'h2: begin
        if (cmd[0]) begin
          r = xi * 2;
          if (r > 32767) r = 32767;
          if (r < -32768) r = -32768;
        end else begin
          r = xi >>> 1;
        end
      end
      default: r = xi;
    endcase
    return r[15:0];
  endfunction

  function automatic logic flag_ref(input logic [15:0] y);
    int yi;
    yi = $signed(y);
    if (yi < 0) yi = -yi;
    return (yi > `VOICE_THRESHOLD);
  endfunction

  task automatic send_byte(input logic [7:0] b, input logic bad);
    @(posedge clk_12M);
    #1 i_uart_rx = 1'b0;  // start bit
    repeat (BIT_CLKS) @(posedge clk_12M);
    for (int i = 0; i < 8; i++) begin
      #1 i_uart_rx = b[i];
      repeat (BIT_CLKS) @(posedge clk_12M);
    end
    if (bad) begin
      #1 i_uart_rx = 1'b0;  // held low past mid-bit and released before a false start
      repeat (BIT_CLKS * 3 / 4) @(posedge clk_12M);
      #1 i_uart_rx = 1'b1;
      repeat (BIT_CLKS / 4 + BIT_CLKS) @(posedge clk_12M);
    end else begin
      #1 i_uart_rx = 1'b1;
      repeat (2 * BIT_CLKS) @(posedge clk_12M);
    end
  endtask

  // drives one frame and records the dac line at sck rise j in bits[j]
  task automatic drive_frame(input logic [15:0] x, output logic [31:0] bits);
    for (int j = 0; j < 32; j++) begin
      repeat (8) @(posedge clk_12M);
      #1 i_i2s_sck = 1'b0;
      i_i2s_ws = (j >= 16);
      i_i2s_sd = (j >= 1 && j <= 16) ? x[16-j] : 1'b0;
      repeat (8) @(posedge clk_12M);
      #1 i_i2s_sck = 1'b1;
      bits[j] = o_i2s_sd;
    end
  endtask

  task automatic run_frame(input logic [15:0] x);
    logic [31:0] bits;
    logic [15:0] left;
    logic [15:0] right;
    logic [15:0] d;
    logic [15:0] y;
    drive_frame(x, bits);
    d = (hist.size() >= `ECHO_DEPTH) ? hist[hist.size() - `ECHO_DEPTH] : 16'h0000;
    y = effect_ref(model_cmd, x, d);
    hist.push_back(x);
    for (int k = 0; k < 16; k++) left[15-k] = bits[k+1];
    for (int k = 0; k < 15; k++) right[15-k] = prev_bits[k+17];
    right[0] = bits[0];  // right lsb lands in the next frame
    if (o_voice_flag != flag_ref(y)) begin
      $display("Error: o_voice_flag frame %0d expected %h got %h",
               frame_cnt, flag_ref(y), o_voice_flag);
      errors++;
    end
    if (frame_cnt >= 1 && left != y_prev) begin
      $display("Error: o_i2s_sd_word left frame %0d expected %h got %h",
               frame_cnt, y_prev, left);
      errors++;
    end
    if (frame_cnt >= 2 && right != y_prev2) begin
      $display("Error: o_i2s_sd_word right frame %0d expected %h got %h",
               frame_cnt - 1, y_prev2, right);
      errors++;
    end
    y_prev2   = y_prev;
    y_prev    = y;
    prev_bits = bits;
    frame_cnt++;
  endtask

  initial begin
    logic [15:0] x;
    void'($urandom(59));
    i_uart_rx    = 1'b1;
    i_i2s_sck    = 1'b1;
    i_i2s_ws     = 1'b1;
    i_i2s_sd     = 1'b0;
    sys_rst      = 1'b0;
    errors       = 0;
    frame_cnt    = 0;
    model_cmd    = 8'h00;
    y_prev       = '0;
    y_prev2      = '0;
    prev_bits    = '0;
    limit_cycles = 0;
    rows[0]  = '{1'b0, 1'b0, 8'h00, 8'd4,  1'b0, 16'h0800};
    rows[1]  = '{1'b0, 1'b0, 8'h00, 8'd2,  1'b0, 16'hE000};
    rows[2]  = '{1'b1, 1'b0, 8'h10, 8'd8,  1'b1, 16'h0000};
    rows[3]  = '{1'b0, 1'b0, 8'h00, 8'd30, 1'b1, 16'h0000};
    rows[4]  = '{1'b1, 1'b0, 8'h21, 8'd6,  1'b1, 16'h0000};
    rows[5]  = '{1'b0, 1'b0, 8'h00, 8'd2,  1'b0, 16'h7FFF};
    rows[6]  = '{1'b0, 1'b0, 8'h00, 8'd2,  1'b0, 16'h8000};
    rows[7]  = '{1'b0, 1'b0, 8'h00, 8'd2,  1'b0, 16'h0900};
    rows[8]  = '{1'b1, 1'b0, 8'h20, 8'd6,  1'b1, 16'h0000};
    rows[9]  = '{1'b0, 1'b0, 8'h00, 8'd2,  1'b0, 16'h8001};
    rows[10] = '{1'b1, 1'b1, 8'h10, 8'd4,  1'b1, 16'h0000};
    rows[11] = '{1'b1, 1'b0, 8'h7A, 8'd4,  1'b1, 16'h0000};
    for (int r = 0; r < NROWS; r++) begin
      limit_cycles += 2 * (longint'(rows[r].frames) * 512);
      if (rows[r].has_cmd) limit_cycles += 2 * 10 * longint'(BIT_CLKS);
    end
    limit_cycles += 100;  // reset and start-up
    repeat (5) @(posedge clk_12M);
    if (o_voice_flag || o_i2s_sd) begin
      $display("outputs were not low during reset");
      errors++;
    end
    repeat (5) @(posedge clk_12M);
    #1 sys_rst = 1'b1;
    @(posedge clk_12M);
    #1;
    if (o_voice_flag) begin
      $display("Error: o_voice_flag after reset expected %h got %h", 1'b0, o_voice_flag);
      errors++;
    end
    for (int r = 0; r < NROWS; r++) begin
      if (rows[r].has_cmd) begin
        send_byte(rows[r].cmd, rows[r].bad_stop);
        if (!rows[r].bad_stop) model_cmd = rows[r].cmd;
      end
      for (int f = 0; f < rows[r].frames; f++) begin
        x = rows[r].rnd ? 16'($urandom()) : rows[r].pattern;
        run_frame(x);
      end
    end
    errors += i_audio_top.u_assert.fail_cnt;
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog sized from the table
  initial begin
    @(posedge sys_rst);
    repeat (limit_cycles) @(posedge clk_12M);
    $display("the run timed out before all table rows were applied");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+hdl
hdl/audio_pkg.sv
hdl/i2s_capture.sv
hdl/cmd_decode.sv
hdl/effect_execute.sv
hdl/audio_result.sv
hdl/audio_top.sv
tb/audio_assert.sv
tb/audio_tb.sv

// File: Makefile
# Verilator build and run of the audio command path testbench

VERILATOR ?= verilator
TOP       ?= audio_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
